// ==== project.f ====
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/rv_int_core.sv
verification/tb_clock_gen.sv
verification/tb_rv_int_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of tb_rv_int_core, run from the project root

rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_int_core \
    -f project.f > build.log 2>&1 &&
./obj_dir/Vtb_rv_int_core > sim.log 2>&1

grep -q "Simulation completed successfully" sim.log &&
    echo "Run passed, see sim.log" ||
    { echo "Run failed, see build.log and sim.log"; exit 1; }

// ==== verification/tb_rv_int_core.sv ====
`default_nettype none
`include "core_cfg.svh"

module tb_rv_int_core
    import pipe_pkg::*;
();

    localparam int DRIVE_DLY    = 2;                            // Inputs change after the edge
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT   = 200;                          // Cycles per wait loop

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;             // Not supported by the core

    // One instruction with the retire record it must produce
    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_INSTR_W-1:0]    instr;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic                        wr_en;
        logic [`CORE_XLEN-1:0]       wdata;
        logic [`CORE_XLEN-1:0]       next_pc;
        logic                        illegal;
    } row_t;

    logic    clk;
    logic    rst;
    logic    in_valid;
    logic    in_ready;
    fetch_t  in_fetch;
    logic    retire_valid;
    logic    retire_ready;
    retire_t retire;
    logic    random_ready;                                      // Back-pressure on in pass 2
    int      pass_no;
    string   ctx;                                               // Pass and row for error lines
    row_t    rows[$];

    tb_clock_gen #(.PERIOD(40)) u_clock_gen (.clk_o(clk));

    rv_int_core u_rv_int_core (
        .clk_i          (clk),
        .rst_i          (rst),
        .in_valid_i     (in_valid),
        .in_ready_o     (in_ready),
        .in_fetch_i     (in_fetch),
        .retire_valid_o (retire_valid),
        .retire_ready_i (retire_ready),
        .retire_o       (retire)
    );

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp)
            report_fail($sformatf("FAILED %s: got 0x%0h, expected 0x%0h (%s)",
                                  name, got, exp, ctx));
    endtask

    // Instruction encoders in RV32I field order
    function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                          logic [6:0] opc);
        return {imm, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                          int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, int rs2, int rs1, logic [2:0] f3);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), OPC_JAL};
    endfunction

    function automatic void add_row(logic [31:0] pc, logic [31:0] instr, int rd, logic we,
                                    logic [31:0] wdata, logic [31:0] npc, logic ill);
        rows.push_back('{pc: pc, instr: instr, rd: 5'(rd), wr_en: we, wdata: wdata,
                         next_pc: npc, illegal: ill});
    endfunction

    // Sequential writer where rd of x0 never writes
    function automatic void add_wr(logic [31:0] pc, logic [31:0] instr, int rd,
                                   logic [31:0] wdata);
        add_row(pc, instr, rd, rd != 0, wdata, pc + 32'd4, 1'b0);
    endfunction

    // Branch record carries the rd field bits that hold part of the offset
    function automatic void add_branch(logic [31:0] pc, logic [2:0] f3, int rs1, int rs2,
                                       logic [12:0] off, logic taken);
        logic [31:0] instr;
        logic [31:0] target;
        instr  = enc_b(off, rs2, rs1, f3);
        target = pc + {{19{off[12]}}, off};
        add_row(pc, instr, instr[11:7], 1'b0, 32'h0, taken ? target : pc + 32'd4, 1'b0);
    endfunction

    function automatic void load_rows();
        add_wr(32'h100, enc_i(12'h123, 5, 3'b000, 1, OPC_OP_IMM), 1, 32'h0000_0123); // x5 is zero
        add_wr(32'h104, enc_i(12'hffb, 0, 3'b000, 2, OPC_OP_IMM), 2, 32'hffff_fffb); // ADDI -5
        add_wr(32'h108, enc_i(12'h001, 2, 3'b010, 3, OPC_OP_IMM), 3, 32'h0000_0001); // SLTI
        add_wr(32'h10c, enc_i(12'h001, 2, 3'b011, 4, OPC_OP_IMM), 4, 32'h0000_0000); // SLTIU
        add_wr(32'h110, enc_i(12'h0ff, 1, 3'b100, 5, OPC_OP_IMM), 5, 32'h0000_01dc); // XORI
        add_wr(32'h114, enc_i(12'h400, 1, 3'b110, 6, OPC_OP_IMM), 6, 32'h0000_0523); // ORI
        add_wr(32'h118, enc_i(12'h0f0, 1, 3'b111, 7, OPC_OP_IMM), 7, 32'h0000_0020); // ANDI
        add_wr(32'h11c, enc_i(12'h004, 1, 3'b001, 8, OPC_OP_IMM), 8, 32'h0000_1230); // SLLI 4
        add_wr(32'h120, enc_i(12'h01c, 2, 3'b101, 9, OPC_OP_IMM), 9, 32'h0000_000f); // SRLI 28
        add_wr(32'h124, enc_i(12'h401, 2, 3'b101, 10, OPC_OP_IMM), 10, 32'hffff_fffd); // SRAI 1
        add_wr(32'h128, {20'habcde, 5'd11, OPC_LUI}, 11, 32'habcd_e000);
        add_wr(32'h12c, {20'h00001, 5'd12, OPC_AUIPC}, 12, 32'h0000_112c);
        add_wr(32'h130, enc_i(12'h007, 1, 3'b000, 0, OPC_OP_IMM), 0, 32'h0000_012a); // To x0
        add_wr(32'h134, enc_i(12'h000, 0, 3'b000, 13, OPC_OP_IMM), 13, 32'h0000_0000);
        // Dependent OP chain
        add_wr(32'h138, enc_r(7'h00, 2, 1, 3'b000, 14), 14, 32'h0000_011e);        // ADD
        add_wr(32'h13c, enc_r(7'h20, 1, 14, 3'b000, 15), 15, 32'hffff_fffb);       // SUB
        add_wr(32'h140, enc_r(7'h00, 3, 15, 3'b001, 16), 16, 32'hffff_fff6);       // SLL by 1
        add_wr(32'h144, enc_r(7'h00, 15, 16, 3'b010, 17), 17, 32'h0000_0001);      // -10 < -5
        add_wr(32'h148, enc_r(7'h00, 17, 16, 3'b011, 18), 18, 32'h0000_0000);      // SLTU
        add_wr(32'h14c, enc_r(7'h00, 14, 16, 3'b100, 19), 19, 32'hffff_fee8);      // XOR
        add_wr(32'h150, enc_r(7'h00, 9, 19, 3'b101, 20), 20, 32'h0001_ffff);       // SRL by 15
        add_wr(32'h154, enc_r(7'h20, 3, 19, 3'b101, 21), 21, 32'hffff_ff74);       // SRA by 1
        add_wr(32'h158, enc_r(7'h00, 20, 21, 3'b110, 22), 22, 32'hffff_ffff);      // OR
        add_wr(32'h15c, enc_r(7'h00, 20, 22, 3'b111, 23), 23, 32'h0001_ffff);      // AND
        // Branches with x1 = 0x123 and x2 = -5
        add_branch(32'h160, 3'b000, 1, 1, 13'h0010, 1'b1);                      // BEQ
        add_branch(32'h170, 3'b000, 1, 2, 13'h0010, 1'b0);
        add_branch(32'h174, 3'b001, 1, 2, 13'h1fc0, 1'b1);                      // BNE back 0x40
        add_branch(32'h134, 3'b001, 1, 1, 13'h0008, 1'b0);
        add_branch(32'h138, 3'b100, 2, 1, 13'h000c, 1'b1);                      // BLT
        add_branch(32'h144, 3'b100, 1, 2, 13'h000c, 1'b0);
        add_branch(32'h148, 3'b101, 1, 2, 13'h0014, 1'b1);                      // BGE
        add_branch(32'h15c, 3'b101, 2, 1, 13'h0014, 1'b0);
        add_branch(32'h160, 3'b110, 1, 2, 13'h0008, 1'b1);                      // BLTU
        add_branch(32'h168, 3'b110, 2, 1, 13'h0008, 1'b0);
        add_branch(32'h16c, 3'b111, 2, 1, 13'h0100, 1'b1);                      // BGEU
        add_branch(32'h26c, 3'b111, 1, 2, 13'h0008, 1'b0);
        // Jumps and an unsupported load
        add_row(32'h270, enc_j(21'h00040, 25), 25, 1'b1, 32'h0000_0274, 32'h0000_02b0, 1'b0);
        add_row(32'h2b0, enc_i(12'h200, 3, 3'b000, 26, OPC_JALR), 26, 1'b1,
                32'h0000_02b4, 32'h0000_0200, 1'b0);                            // 0x201 with bit 0 off
        add_row(32'h200, enc_i(12'h000, 1, 3'b010, 27, OPC_LOAD), 27, 1'b0,
                32'h0000_0000, 32'h0000_0204, 1'b1);
        add_wr(32'h204, enc_r(7'h00, 26, 25, 3'b000, 28), 28, 32'h0000_0528);      // Sum of links
    endfunction

    task automatic drive_ready();
        forever
        begin
            @(posedge clk);
            #DRIVE_DLY;
            retire_ready = random_ready ? ($urandom % 4 != 0) : 1'b1;         // Ready 3 of 4
        end
    endtask

    task automatic apply_reset();
        rst      = 1'b1;
        in_valid = 1'b0;
        ctx      = $sformatf("pass %0d, reset", pass_no);
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            check_val("retire_valid_o", retire_valid, 1'b0);
        end
        rst = 1'b0;
        @(negedge clk);
        check_val("retire_valid_o", retire_valid, 1'b0);                      // Still empty
        check_val("in_ready_o", in_ready, 1'b1);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic feed_rows();
        int cycles;
        foreach (rows[i])
        begin
            in_valid = 1'b1;
            in_fetch = '{pc: rows[i].pc, instr: rows[i].instr};
            cycles   = 0;
            do
            begin
                @(negedge clk);                                 // Transfer decided here
                cycles++;
                if (cycles > WAIT_LIMIT)
                    report_fail($sformatf("Timeout: row %0d of pass %0d was never accepted",
                                          i, pass_no));
            end
            while (!in_ready);
            @(posedge clk);
            #DRIVE_DLY;
        end
        in_valid = 1'b0;
    endtask

    task automatic check_record(row_t r);
        check_val("retire_o.pc", retire.pc, r.pc);
        check_val("retire_o.rd", retire.rd, r.rd);
        check_val("retire_o.wr_en", retire.wr_en, r.wr_en);
        check_val("retire_o.wdata", retire.wdata, r.wdata);
        check_val("retire_o.next_pc", retire.next_pc, r.next_pc);
        check_val("retire_o.illegal", retire.illegal, r.illegal);
    endtask

    task automatic check_rows();
        retire_t held;
        logic    holding;
        logic    got_it;
        int      cycles;
        holding = 1'b0;
        held    = '0;
        foreach (rows[i])
        begin
            ctx    = $sformatf("pass %0d, row %0d", pass_no, i);
            got_it = 1'b0;
            cycles = 0;
            while (!got_it)
            begin
                @(negedge clk);
                if (holding)                                    // Stalled record must not move
                begin
                    check_val("retire_valid_o", retire_valid, 1'b1);
                    check_val("retire_o", retire, held);
                end
                if (retire_valid && retire_ready)
                begin
                    check_record(rows[i]);
                    got_it  = 1'b1;
                    holding = 1'b0;
                end
                else
                begin
                    holding = retire_valid;
                    held    = retire;
                    cycles++;
                    if (cycles > WAIT_LIMIT)
                        report_fail($sformatf("Timeout: no retire record for %s", ctx));
                end
            end
        end
    endtask

    task automatic run_pass(int num, logic rnd);
        pass_no      = num;
        random_ready = rnd;
        apply_reset();                                          // Clean register file each pass
        fork
            feed_rows();
            check_rows();
        join
        ctx = $sformatf("pass %0d, after the last row", num);
        @(posedge clk);                                         // Last record leaves here
        #DRIVE_DLY;
        check_val("retire_valid_o", retire_valid, 1'b0);        // No extra record behind it
    endtask

    initial
    begin
        void'($urandom(32'h4218));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_fetch     = '0;
        retire_ready = 1'b0;
        random_ready = 1'b0;
        pass_no      = 0;
        ctx          = "start";
        load_rows();
        fork
            drive_ready();
        join_none
        run_pass(1, 1'b0);
        run_pass(2, 1'b1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD = 40                                   // Time units per cycle
)
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;                                           // Low at time zero, no edge yet
        forever
            #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== logic/rv_int_core.sv ====
`default_nettype none
`include "core_cfg.svh"

module rv_int_core
    import pipe_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    rst_i,
    input  wire logic    in_valid_i,
    output logic         in_ready_o,
    input  wire fetch_t  in_fetch_i,
    output logic         retire_valid_o,
    input  wire logic    retire_ready_i,
    output retire_t      retire_o
);

    logic                        dec_valid, dec_ready;
    dec_t                        dec_data;
    logic                        exe_valid, exe_ready;
    retire_t                     exe_data;
    pending_t                    exe_pending, res_pending;    // Hazard feedback
    logic [`CORE_REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [`CORE_XLEN-1:0]       rs1_data, rs2_data;

    decode_stage u_decode_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .in_fetch_i    (in_fetch_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .exe_pending_i (exe_pending),
        .res_pending_i (res_pending),
        .dec_valid_o   (dec_valid),
        .dec_ready_i   (dec_ready),
        .dec_o         (dec_data)
    );

    execute_stage u_execute_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .dec_valid_i   (dec_valid),
        .dec_ready_o   (dec_ready),
        .dec_i         (dec_data),
        .exe_valid_o   (exe_valid),
        .exe_ready_i   (exe_ready),
        .exe_o         (exe_data),
        .exe_pending_o (exe_pending)
    );

    result_stage u_result_stage (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .exe_valid_i    (exe_valid),
        .exe_ready_o    (exe_ready),
        .exe_i          (exe_data),
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .res_pending_o  (res_pending),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i),
        .retire_o       (retire_o)
    );

endmodule

`default_nettype wire

// ==== logic/result_stage.sv ====
`default_nettype none
`include "core_cfg.svh"

module result_stage
    import pipe_pkg::*;
(
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic                        exe_valid_i,
    output logic                             exe_ready_o,
    input  wire retire_t                     exe_i,
    input  wire logic [`CORE_REG_ADDR_W-1:0] rs1_addr_i,
    input  wire logic [`CORE_REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`CORE_XLEN-1:0]            rs1_data_o,
    output logic [`CORE_XLEN-1:0]            rs2_data_o,
    output pending_t                         res_pending_o,
    output logic                             retire_valid_o,
    input  wire logic                        retire_ready_i,
    output retire_t                          retire_o
);

    localparam int NUM_REGS = 1 << `CORE_REG_ADDR_W;

    logic [`CORE_XLEN-1:0] regs [1:NUM_REGS-1];              // x0 has no storage
    logic                  retire_fire;
    logic                  wr_fire;

    assign retire_fire = retire_valid_o && retire_ready_i;
    assign wr_fire     = retire_fire && retire_o.wr_en;      // Write with the handshake
    assign exe_ready_o = !retire_valid_o || retire_ready_i;

    assign res_pending_o = '{valid: retire_valid_o, rd: retire_o.rd, wr_en: retire_o.wr_en};

    // Combinational read ports for decode
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            retire_valid_o <= 1'b0;
            retire_o       <= '0;
        end
        else if (exe_ready_o)
        begin
            retire_valid_o <= exe_valid_i;
            if (exe_valid_i)
                retire_o <= exe_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;                               // Architectural state starts at zero
        end
        else if (wr_fire)
        begin
            regs[retire_o.rd] <= retire_o.wdata;
        end
    end

    // Decode must have dropped wr_en for rd of zero
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o && retire_o.wr_en |-> retire_o.rd != '0);

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`default_nettype none
`include "core_cfg.svh"

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire logic     dec_valid_i,
    output logic          dec_ready_o,
    input  wire dec_t     dec_i,
    output logic          exe_valid_o,
    input  wire logic     exe_ready_i,
    output retire_t       exe_o,
    output pending_t      exe_pending_o
);

    logic [`CORE_XLEN-1:0]    op_a, op_b;
    logic [`CORE_SHAMT_W-1:0] shamt;
    logic [`CORE_XLEN-1:0]    alu_res;
    logic                     taken;
    logic [`CORE_XLEN-1:0]    pc_plus_step, pc_plus_imm, jalr_sum;
    logic [`CORE_XLEN-1:0]    wdata, next_pc;
    retire_t                  exe_next;

    assign op_a  = dec_i.op_a;
    assign op_b  = dec_i.op_b;
    assign shamt = op_b[`CORE_SHAMT_W-1:0];                 // Upper bits ignored

    always_comb
    begin
        case (dec_i.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $signed(op_a) >>> shamt;    // Sign bit fills in
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = '0;
        endcase
    end

    always_comb
    begin
        case (dec_i.br_cond)
            BR_EQ:   taken = (op_a == op_b);
            BR_NE:   taken = (op_a != op_b);
            BR_LT:   taken = $signed(op_a) < $signed(op_b);
            BR_GE:   taken = $signed(op_a) >= $signed(op_b);
            BR_LTU:  taken = op_a < op_b;
            BR_GEU:  taken = op_a >= op_b;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus_step = dec_i.pc + `CORE_PC_STEP;
    assign pc_plus_imm  = dec_i.pc + dec_i.imm;
    assign jalr_sum     = op_a + dec_i.imm;

    always_comb
    begin
        wdata   = alu_res;
        next_pc = pc_plus_step;                             // Sequential by default
        case (dec_i.kind)
            KIND_LUI:   wdata = dec_i.imm;
            KIND_AUIPC: wdata = pc_plus_imm;
            KIND_JAL:
            begin
                wdata   = pc_plus_step;                     // Link address
                next_pc = pc_plus_imm;
            end
            KIND_JALR:
            begin
                wdata   = pc_plus_step;
                next_pc = {jalr_sum[`CORE_XLEN-1:1], 1'b0};
            end
            KIND_BRANCH:
            begin
                wdata = '0;                                 // Nothing to write
                if (taken)
                    next_pc = pc_plus_imm;
            end
            KIND_ILLEGAL: wdata = '0;
            default: ;
        endcase
    end

    assign exe_next = '{pc: dec_i.pc, rd: dec_i.rd, wr_en: dec_i.wr_en, wdata: wdata,
                        next_pc: next_pc, illegal: dec_i.illegal};

    assign dec_ready_o   = !exe_valid_o || exe_ready_i;
    assign exe_pending_o = '{valid: exe_valid_o, rd: exe_o.rd, wr_en: exe_o.wr_en};

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            exe_valid_o <= 1'b0;
            exe_o       <= '0;
        end
        else if (dec_ready_o)
        begin
            exe_valid_o <= dec_valid_i;
            if (dec_valid_i)
                exe_o <= exe_next;
        end
    end

    // Held record must not change until result takes it
    a_exe_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        exe_valid_o && !exe_ready_i |=> exe_valid_o && $stable(exe_o));

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none
`include "core_cfg.svh"

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic                        in_valid_i,
    output logic                             in_ready_o,
    input  wire fetch_t                      in_fetch_i,
    output logic [`CORE_REG_ADDR_W-1:0]      rs1_addr_o,
    output logic [`CORE_REG_ADDR_W-1:0]      rs2_addr_o,
    input  wire logic [`CORE_XLEN-1:0]       rs1_data_i,
    input  wire logic [`CORE_XLEN-1:0]       rs2_data_i,
    input  wire pending_t                    exe_pending_i,
    input  wire pending_t                    res_pending_i,
    output logic                             dec_valid_o,
    input  wire logic                        dec_ready_i,
    output dec_t                             dec_o
);

    logic [`CORE_INSTR_W-1:0]    instr;
    opcode_e                     opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic [`CORE_XLEN-1:0]       imm_i, imm_u, imm_b, imm_j, imm_sh;
    logic                        f7_zero, f7_alt, alt_ok;
    instr_kind_e                 kind;
    alu_op_e                     alu_op;
    logic [`CORE_XLEN-1:0]       imm;
    logic                        use_rs1, use_rs2;
    pending_t                    own_pending;
    logic                        hazard;
    dec_t                        dec_next;

    assign instr  = in_fetch_i.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1_addr_o = instr[19:15];                    // Read every cycle and used only when needed
    assign rs2_addr_o = instr[24:20];

    assign imm_i  = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_b  = {{(`CORE_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                     instr[11:8], 1'b0};
    assign imm_j  = {{(`CORE_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                     instr[30:21], 1'b0};
    assign imm_sh = {{(`CORE_XLEN-`CORE_SHAMT_W){1'b0}}, instr[20 +: `CORE_SHAMT_W]};

    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);              // SUB and SRA form
    assign alt_ok  = (funct3 == 3'b000) || (funct3 == 3'b101);

    always_comb
    begin
        kind    = KIND_ILLEGAL;                           // Anything unmatched
        alu_op  = ALU_ADD;
        imm     = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_LUI:
            begin
                kind = KIND_LUI;
                imm  = imm_u;
            end
            OPC_AUIPC:
            begin
                kind = KIND_AUIPC;
                imm  = imm_u;
            end
            OPC_JAL:
            begin
                kind = KIND_JAL;
                imm  = imm_j;
            end
            OPC_JALR:
            begin
                if (funct3 == 3'b000)
                begin
                    kind    = KIND_JALR;
                    imm     = imm_i;
                    use_rs1 = 1'b1;
                end
            end
            OPC_BRANCH:
            begin
                if (funct3[2:1] != 2'b01)                 // Skip reserved conditions
                begin
                    kind    = KIND_BRANCH;
                    imm     = imm_b;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            OPC_OP_IMM:
            begin
                if (funct3 == 3'b101)                     // SRLI or SRAI
                begin
                    if (f7_zero || f7_alt)
                    begin
                        kind    = KIND_ALU;
                        alu_op  = alu_op_e'({funct7[5], funct3});
                        imm     = imm_sh;
                        use_rs1 = 1'b1;
                    end
                end
                else if (funct3 != 3'b001 || f7_zero)     // SLLI needs funct7 zero
                begin
                    kind    = KIND_ALU;
                    alu_op  = alu_op_e'({1'b0, funct3});
                    imm     = imm_i;                      // Plain shift amount for SLLI
                    use_rs1 = 1'b1;
                end
            end
            OPC_OP:
            begin
                if (f7_zero || (f7_alt && alt_ok))
                begin
                    kind    = KIND_ALU;
                    alu_op  = alu_op_e'({funct7[5], funct3});
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            default: ;
        endcase
    end

    function automatic logic pend_hit(pending_t p, logic [`CORE_REG_ADDR_W-1:0] addr);
        return p.valid && p.wr_en && (p.rd == addr);
    endfunction

    // Own register counts as the youngest item in flight
    assign own_pending = '{valid: dec_valid_o, rd: dec_o.rd, wr_en: dec_o.wr_en};

    assign hazard = (use_rs1 && (pend_hit(own_pending, rs1_addr_o) ||
                                 pend_hit(exe_pending_i, rs1_addr_o) ||
                                 pend_hit(res_pending_i, rs1_addr_o))) ||
                    (use_rs2 && (pend_hit(own_pending, rs2_addr_o) ||
                                 pend_hit(exe_pending_i, rs2_addr_o) ||
                                 pend_hit(res_pending_i, rs2_addr_o)));

    assign in_ready_o = (!dec_valid_o || dec_ready_i) && !hazard;

    assign dec_next = '{
        pc:      in_fetch_i.pc,
        op_a:    rs1_data_i,
        op_b:    use_rs2 ? rs2_data_i : imm,               // Branch compares rs1 with rs2
        imm:     imm,
        alu_op:  alu_op,
        kind:    kind,
        br_cond: br_cond_e'(funct3),
        rd:      rd,
        wr_en:   (kind != KIND_BRANCH) && (kind != KIND_ILLEGAL) && (rd != '0),
        illegal: (kind == KIND_ILLEGAL)
    };

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            dec_valid_o <= 1'b0;
            dec_o       <= '0;
        end
        else if (!dec_valid_o || dec_ready_i)              // Empty or draining
        begin
            dec_valid_o <= in_valid_i && !hazard;          // Bubble while stalled
            if (in_valid_i && !hazard)
                dec_o <= dec_next;
        end
    end

    // Feeder keeps the offer until it is taken
    a_in_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_fetch_i));

endmodule

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`default_nettype none
`include "core_cfg.svh"

package pipe_pkg;

    import isa_pkg::*;

    // Offered by the feeder
    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_INSTR_W-1:0]    instr;
    } fetch_t;

    // Decode to execute
    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_XLEN-1:0]       op_a;          // rs1 value
        logic [`CORE_XLEN-1:0]       op_b;          // rs2 value or immediate
        logic [`CORE_XLEN-1:0]       imm;           // Branch and jump offset
        alu_op_e                     alu_op;
        instr_kind_e                 kind;
        br_cond_e                    br_cond;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic                        wr_en;         // Already low for x0
        logic                        illegal;
    } dec_t;

    // Execute to result, and the retire record itself
    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic                        wr_en;
        logic [`CORE_XLEN-1:0]       wdata;
        logic [`CORE_XLEN-1:0]       next_pc;
        logic                        illegal;
    } retire_t;

    // Destination of an item still in flight
    typedef struct packed {
        logic                        valid;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic                        wr_en;
    } pending_t;

endpackage

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // ALU op is {funct7[5], funct3} so decode needs no lookup
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    // Branch funct3 codes, 010 and 011 are reserved
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    // What execute does with an instruction
    typedef enum logic [2:0] {
        KIND_ALU,                                   // OP and OP-IMM
        KIND_LUI,
        KIND_AUIPC,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_ILLEGAL                                // Retired with flag, no write
    } instr_kind_e;

endpackage

`default_nettype wire

// ==== logic/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path and PC width
`define CORE_XLEN        32
// Uncompressed encodings only
`define CORE_INSTR_W     32
// Register index, x0 to x31
`define CORE_REG_ADDR_W  5
// Shift amount bits for RV32
`define CORE_SHAMT_W     5
// Byte distance to the sequential successor
`define CORE_PC_STEP     4

`endif
